// File: hw/fetch_pkg.sv
package fetch_pkg;

  parameter int ADDR_W = 32;  // Byte address.
  parameter int DATA_W = 32;  // Instruction word.
  parameter int IDX_W  = 5;   // 32 cache lines.
  parameter int OPC_W  = 4;   // Opcode in bits 31..28.

  // Tag is the address above the index and the byte offset.
  parameter int TAG_W = ADDR_W - IDX_W - 2;

  typedef enum logic {
    IFU_IDLE,        // Looking up or waiting on the bus.
    IFU_WAIT_READY   // Word held until the consumer takes it.
  } ifu_state_e;

  typedef enum logic [OPC_W-1:0] {
    OP_NOP  = 4'h0,
    OP_ADDI = 4'h1,  // Acc += sext(imm16).
    OP_SETC = 4'h2,  // Cnt = imm16.
    OP_DJNZ = 4'h3,  // Cnt -= 1, jump to imm16 if nonzero.
    OP_JMP  = 4'h4,  // Jump to imm16.
    OP_HALT = 4'h5
  } opcode_e;

endpackage

// File: hw/fetch_top.sv
`timescale 1ns/100ps

module fetch_top #(
  parameter int MEM_LAT   = 3,
  parameter int MEM_WORDS = 256
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        run_i,
  input  logic                        load_we_i,
  input  logic [fetch_pkg::ADDR_W-1:0] load_addr_i,
  input  logic [fetch_pkg::DATA_W-1:0] load_data_i,
  output logic [fetch_pkg::DATA_W-1:0] acc_o,
  output logic [fetch_pkg::DATA_W-1:0] retired_o,
  output logic [fetch_pkg::DATA_W-1:0] bus_reads_o,
  output logic                        halted_o
);
  import fetch_pkg::*;

  logic [ADDR_W-1:0] pc;
  logic [ADDR_W-1:0] npc;
  logic              fetch_req;
  logic              inst_valid;
  logic [DATA_W-1:0] inst;
  logic [ADDR_W-1:0] inst_pc;
  logic              retire_ready;
  logic              redirect;
  logic [ADDR_W-1:0] redirect_pc;
  logic [ADDR_W-1:0] mem_araddr;
  logic              mem_arvalid;
  logic [DATA_W-1:0] mem_rdata;
  logic              mem_rvalid;
  logic              xfer;

  assign xfer = inst_valid & retire_ready;  // Fetch to retire handoff.

  pc_gen i_pc_gen (
    .clk(clk), .rst(rst), .run_i(run_i), .xfer_i(xfer),
    .redirect_i(redirect), .redirect_pc_i(redirect_pc),
    .pc_o(pc), .npc_o(npc), .fetch_req_o(fetch_req)
  );

  icache_ifu i_icache_ifu (
    .clk(clk), .rst(rst), .fetch_req_i(fetch_req), .retire_ready_i(retire_ready),
    .pc_i(pc), .npc_i(npc), .mem_rdata_i(mem_rdata), .mem_rvalid_i(mem_rvalid),
    .inst_valid_o(inst_valid), .inst_o(inst), .inst_pc_o(inst_pc),
    .mem_araddr_o(mem_araddr), .mem_arvalid_o(mem_arvalid)
  );

  inst_mem #(
    .MEM_LAT(MEM_LAT),
    .MEM_WORDS(MEM_WORDS)
  ) i_inst_mem (
    .clk(clk), .rst(rst), .araddr_i(mem_araddr), .arvalid_i(mem_arvalid),
    .load_we_i(load_we_i), .load_addr_i(load_addr_i), .load_data_i(load_data_i),
    .rdata_o(mem_rdata), .rvalid_o(mem_rvalid), .bus_reads_o(bus_reads_o)
  );

  inst_retire i_inst_retire (
    .clk(clk), .rst(rst), .inst_valid_i(inst_valid), .inst_i(inst), .inst_pc_i(inst_pc),
    .ready_o(retire_ready), .redirect_o(redirect), .redirect_pc_o(redirect_pc),
    .acc_o(acc_o), .retired_o(retired_o), .halted_o(halted_o)
  );

endmodule

// File: hw/icache_ifu.sv
`timescale 1ns/100ps

module icache_ifu (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        fetch_req_i,
  input  logic                        retire_ready_i,
  input  logic [fetch_pkg::ADDR_W-1:0] pc_i,
  input  logic [fetch_pkg::ADDR_W-1:0] npc_i,
  input  logic [fetch_pkg::DATA_W-1:0] mem_rdata_i,
  input  logic                        mem_rvalid_i,
  output logic                        inst_valid_o,
  output logic [fetch_pkg::DATA_W-1:0] inst_o,
  output logic [fetch_pkg::ADDR_W-1:0] inst_pc_o,
  output logic [fetch_pkg::ADDR_W-1:0] mem_araddr_o,
  output logic                        mem_arvalid_o
);
  import fetch_pkg::*;

  localparam int LINES = 2 ** IDX_W;

  ifu_state_e        state_q;
  logic              pend_q;
  logic [DATA_W-1:0] inst_q;

  logic [DATA_W-1:0] line_data [LINES];
  logic [TAG_W-1:0]  line_tag [LINES];
  logic [LINES-1:0]  line_valid;

  logic [ADDR_W-1:0] fetch_addr;
  logic [IDX_W-1:0]  idx;
  logic [TAG_W-1:0]  tag;
  logic              active;
  logic              hit;
  logic              xfer;

  assign fetch_addr = fetch_req_i ? npc_i : pc_i;
  assign idx        = fetch_addr[IDX_W+1:2];
  assign tag        = fetch_addr[ADDR_W-1:IDX_W+2];
  assign active     = fetch_req_i | pend_q;  // A fetch is outstanding.
  assign hit        = active & line_valid[idx] & (line_tag[idx] == tag);

  // Bus read stays up until the data returns.
  assign mem_araddr_o  = fetch_addr;
  assign mem_arvalid_o = (state_q == IFU_IDLE) & active & ~hit & ~mem_rvalid_i;

  always_comb
  begin
    if (state_q == IFU_WAIT_READY)
    begin
      inst_valid_o = 1'b1;
      inst_o       = inst_q;
    end
    else
    begin
      inst_valid_o = hit | mem_rvalid_i;
      inst_o       = mem_rvalid_i ? mem_rdata_i : line_data[idx];  // Bypass on refill.
    end
  end

  assign inst_pc_o = fetch_addr;  // Held steady while the word waits.
  assign xfer      = inst_valid_o & retire_ready_i;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q    <= IFU_IDLE;
      pend_q     <= 1'b0;
      line_valid <= '0;
    end
    else
    begin
      pend_q <= active & ~xfer;
      if (mem_rvalid_i)
        line_valid[idx] <= 1'b1;
      case (state_q)
        IFU_IDLE:
          if (inst_valid_o && !retire_ready_i)
            state_q <= IFU_WAIT_READY;  // Consumer stalled.
        IFU_WAIT_READY:
          if (retire_ready_i)
            state_q <= IFU_IDLE;
        default:
          state_q <= IFU_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (mem_rvalid_i)
    begin
      line_data[idx] <= mem_rdata_i;
      line_tag[idx]  <= tag;
    end
    if (state_q == IFU_IDLE && inst_valid_o)
      inst_q <= inst_o;
  end

  // A word just refilled hits, so the bus is not asked for it again.
  a_no_bus_on_hit: assert property (@(posedge clk) disable iff (rst)
    mem_rvalid_i |=> !(mem_arvalid_o && mem_araddr_o == $past(mem_araddr_o)));

  a_rvalid_requested: assert property (@(posedge clk) disable iff (rst)
    mem_rvalid_i |-> $past(mem_arvalid_o));

endmodule

// File: hw/inst_mem.sv
`timescale 1ns/100ps

module inst_mem #(
  parameter int MEM_LAT   = 3,
  parameter int MEM_WORDS = 256
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [fetch_pkg::ADDR_W-1:0] araddr_i,
  input  logic                        arvalid_i,
  input  logic                        load_we_i,
  input  logic [fetch_pkg::ADDR_W-1:0] load_addr_i,
  input  logic [fetch_pkg::DATA_W-1:0] load_data_i,
  output logic [fetch_pkg::DATA_W-1:0] rdata_o,
  output logic                        rvalid_o,
  output logic [fetch_pkg::DATA_W-1:0] bus_reads_o
);
  import fetch_pkg::*;

  localparam int WA_W  = $clog2(MEM_WORDS);
  localparam int CNT_W = $clog2(MEM_LAT + 1);

  logic [DATA_W-1:0] mem [MEM_WORDS];
  logic [WA_W-1:0]   rd_word_q;
  logic [CNT_W-1:0]  cnt_q;
  logic              busy_q;
  logic [DATA_W-1:0] reads_q;
  logic              accept;

  assign accept      = arvalid_i & ~busy_q;  // One read at a time.
  assign rvalid_o    = busy_q & (cnt_q == '0);
  assign rdata_o     = mem[rd_word_q];
  assign bus_reads_o = reads_q;

  always_ff @(posedge clk)
  begin
    if (load_we_i)
      mem[load_addr_i[WA_W+1:2]] <= load_data_i;  // Preload port.
    if (accept)
      rd_word_q <= araddr_i[WA_W+1:2];
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      busy_q  <= 1'b0;
      cnt_q   <= '0;
      reads_q <= '0;
    end
    else if (accept)
    begin
      busy_q  <= 1'b1;
      cnt_q   <= CNT_W'(MEM_LAT);  // Data out MEM_LAT cycles later.
      reads_q <= reads_q + 1'b1;
    end
    else if (busy_q)
    begin
      if (cnt_q == '0)
        busy_q <= 1'b0;  // Free again after the data beat.
      else
        cnt_q <= cnt_q - 1'b1;
    end
  end

endmodule

// File: hw/inst_retire.sv
`timescale 1ns/100ps

module inst_retire (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        inst_valid_i,
  input  logic [fetch_pkg::DATA_W-1:0] inst_i,
  input  logic [fetch_pkg::ADDR_W-1:0] inst_pc_i,
  output logic                        ready_o,
  output logic                        redirect_o,
  output logic [fetch_pkg::ADDR_W-1:0] redirect_pc_o,
  output logic [fetch_pkg::DATA_W-1:0] acc_o,
  output logic [fetch_pkg::DATA_W-1:0] retired_o,
  output logic                        halted_o
);
  import fetch_pkg::*;

  opcode_e           op;
  logic [15:0]       imm;
  logic [15:0]       cnt_q;
  logic [15:0]       cnt_dec;
  logic [DATA_W-1:0] acc_q;
  logic [DATA_W-1:0] retired_q;
  logic              halted_q;
  logic              take;
  logic              xfer;

  assign op      = opcode_e'(inst_i[DATA_W-1 -: OPC_W]);
  assign imm     = inst_i[15:0];
  assign cnt_dec = cnt_q - 16'd1;

  // HALT retires without being taken, so the word stays parked in the fetch unit.
  assign take    = inst_valid_i & ~halted_q;
  assign ready_o = ~halted_q & ~(inst_valid_i & (op == OP_HALT));
  assign xfer    = inst_valid_i & ready_o;

  assign redirect_pc_o = {{(ADDR_W-16){1'b0}}, imm};  // Absolute byte target.
  assign acc_o         = acc_q;
  assign retired_o     = retired_q;
  assign halted_o      = halted_q;

  always_comb
  begin
    redirect_o = 1'b0;
    if (xfer)
      case (op)
        OP_JMP:  redirect_o = 1'b1;
        OP_DJNZ: redirect_o = (cnt_dec != 16'd0);
        default: redirect_o = 1'b0;
      endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      acc_q     <= '0;
      cnt_q     <= '0;
      retired_q <= '0;
      halted_q  <= 1'b0;
    end
    else if (take)
    begin
      retired_q <= retired_q + 1'b1;
      case (op)
        OP_ADDI: acc_q <= acc_q + {{(DATA_W-16){imm[15]}}, imm};
        OP_SETC: cnt_q <= imm;
        OP_DJNZ: cnt_q <= cnt_dec;
        OP_HALT: halted_q <= 1'b1;
        default: ;  // NOP and undefined codes.
      endcase
    end
  end

  // A jump is a taken JMP or DJNZ, and the next word shown comes from its target.
  a_redirect_src: assert property (@(posedge clk) disable iff (rst)
    redirect_o |-> xfer && (op == OP_JMP || op == OP_DJNZ)
      ##1 (!inst_valid_i || inst_pc_i == $past(redirect_pc_o)));

endmodule

// File: hw/pc_gen.sv
`timescale 1ns/100ps

module pc_gen (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        run_i,
  input  logic                        xfer_i,
  input  logic                        redirect_i,
  input  logic [fetch_pkg::ADDR_W-1:0] redirect_pc_i,
  output logic [fetch_pkg::ADDR_W-1:0] pc_o,
  output logic [fetch_pkg::ADDR_W-1:0] npc_o,
  output logic                        fetch_req_o
);
  import fetch_pkg::*;

  logic [ADDR_W-1:0] pc_q;
  logic [ADDR_W-1:0] npc_q;
  logic [ADDR_W-1:0] cur_addr;
  logic              req_q;
  logic              started_q;

  assign cur_addr    = req_q ? npc_q : pc_q;  // Address being fetched now.
  assign pc_o        = pc_q;
  assign npc_o       = npc_q;
  assign fetch_req_o = req_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pc_q      <= '0;
      req_q     <= 1'b0;
      started_q <= 1'b0;
    end
    else
    begin
      if (req_q)
        pc_q <= npc_q;  // New address becomes the held one.
      if (xfer_i)
        req_q <= 1'b1;
      else if (run_i && !started_q)
      begin
        req_q     <= 1'b1;  // First fetch from address 0.
        started_q <= 1'b1;
      end
      else
        req_q <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (xfer_i)
      npc_q <= redirect_i ? redirect_pc_i : cur_addr + ADDR_W'(4);
    else if (run_i && !started_q)
      npc_q <= '0;
  end

  // Jump targets come from the retire unit and must stay word aligned.
  a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
    fetch_req_o |-> npc_o[1:0] == 2'b00 ##1 pc_o[1:0] == 2'b00);

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module fetch_tb -o fetch_sim
out="$(./obj_dir/fetch_sim)"
echo "$out"

if grep -q "All checks passed" <<< "$out"; then
  exit 0
else
  exit 1
fi

// File: sim/fetch_stim.txt
# Records: P starts a program, W <addr> <word> loads a word, E <acc> <retired> <bus_reads> runs.
# All values are hex; the cache is direct mapped with index bits 6..2 and tag bits 31..7.
P
W 00000000 10000003
W 00000004 1000FFFE
W 00000008 10000100
W 0000000C 50000000
E 00000101 00000004 00000004  # Straight line, every fetch a cold miss.
P
W 00000000 20000005
W 00000004 10000007
W 00000008 30000004
W 0000000C 50000000
E 00000023 0000000C 00000004  # Loop body hits after the first pass.
P
W 00000000 10000001
W 00000004 4000000C
W 00000008 10000100
W 0000000C 10000020
W 00000010 50000000
E 00000021 00000004 00000004  # Word at 0x08 skipped and never read.
P
W 00000000 20000003
W 00000004 10000001
W 00000008 40000084
W 00000084 10000010
W 00000088 30000004
W 0000008C 50000000
E 00000033 0000000E 0000000E  # Lines 1 and 2 evicted on every pass.
P
W 00000000 10000004
W 00000004 F0001234
W 00000008 70000005
W 0000000C 1000FFFF
W 00000010 50000000
E 00000003 00000005 00000005  # Undefined opcodes retire as no-ops.

// File: sim/fetch_tb.sv
`timescale 1ns/100ps

module fetch_tb;
  import fetch_pkg::*;

  localparam int MEM_LAT      = 3;
  localparam int MEM_WORDS    = 256;
  localparam int HALT_TIMEOUT = 2000;  // Cycles allowed per program.
  localparam int HOLD_CYCLES  = 20;    // Idle cycles checked after halt.

  logic              clk;
  logic              rst;
  logic              run_i;
  logic              load_we_i;
  logic [ADDR_W-1:0] load_addr_i;
  logic [DATA_W-1:0] load_data_i;
  logic [DATA_W-1:0] acc_o;
  logic [DATA_W-1:0] retired_o;
  logic [DATA_W-1:0] bus_reads_o;
  logic              halted_o;

  int errors;
  int checks;
  int programs;

  fetch_top #(
    .MEM_LAT(MEM_LAT),
    .MEM_WORDS(MEM_WORDS)
  ) i_dut (
    .clk(clk), .rst(rst), .run_i(run_i), .load_we_i(load_we_i),
    .load_addr_i(load_addr_i), .load_data_i(load_data_i),
    .acc_o(acc_o), .retired_o(retired_o), .bus_reads_o(bus_reads_o), .halted_o(halted_o)
  );

  always #5 clk = ~clk;

  task automatic check_word(input string name, input logic [DATA_W-1:0] actual,
                            input logic [DATA_W-1:0] expected);
    checks++;
    assert (actual === expected)
    else
    begin
      errors++;
      $display("FAIL time=%0t %s expected=0x%08h actual=0x%08h", $time, name, expected, actual);
    end
  endtask

  task automatic apply_reset();
    @(negedge clk);
    rst       = 1'b1;
    run_i     = 1'b0;
    load_we_i = 1'b0;
    repeat (4) @(negedge clk);
    rst = 1'b0;
  endtask

  // Preload one word while the subsystem sits idle.
  task automatic load_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    @(negedge clk);
    load_we_i   = 1'b1;
    load_addr_i = addr;
    load_data_i = data;
    @(negedge clk);
    load_we_i = 1'b0;
  endtask

  task automatic run_program(input logic [DATA_W-1:0] exp_acc,
                             input logic [DATA_W-1:0] exp_retired,
                             input logic [DATA_W-1:0] exp_reads, output bit timed_out);
    int cycles;
    timed_out = 1'b0;
    cycles    = 0;
    @(negedge clk);
    run_i = 1'b1;
    while (!halted_o && cycles < HALT_TIMEOUT)
    begin
      @(negedge clk);
      cycles++;
    end
    if (!halted_o)
    begin
      errors++;
      timed_out = 1'b1;
      $display("Program %0d did not halt within %0d cycles", programs, HALT_TIMEOUT);
    end
    else
    begin
      check_word("acc_o", acc_o, exp_acc);
      check_word("retired_o", retired_o, exp_retired);
      check_word("bus_reads_o", bus_reads_o, exp_reads);
      repeat (HOLD_CYCLES) @(negedge clk);  // HALT keeps the fetch unit stalled.
      check_word("retired_o", retired_o, exp_retired);
      check_word("bus_reads_o", bus_reads_o, exp_reads);
      check_word("halted_o", DATA_W'(halted_o), DATA_W'(1));
    end
    run_i = 1'b0;
  endtask

  initial
  begin
    int                fd;
    int                c;
    int                code;
    logic [7:0]        kind;
    logic [DATA_W-1:0] f1;
    logic [DATA_W-1:0] f2;
    logic [DATA_W-1:0] f3;
    bit                done;
    bit                timed_out;
    clk         = 1'b0;
    rst         = 1'b1;
    run_i       = 1'b0;
    load_we_i   = 1'b0;
    load_addr_i = '0;
    load_data_i = '0;
    errors      = 0;
    checks      = 0;
    programs    = 0;
    fd   = $fopen("sim/fetch_stim.txt", "r");
    done = (fd == 0);
    if (fd == 0)
    begin
      errors++;
      $display("Could not open the stim file sim/fetch_stim.txt");
    end
    while (!done)
    begin
      c    = $fgetc(fd);
      kind = c[7:0];
      if (c < 0)
        done = 1'b1;
      else if (kind == "#")
        while (c >= 0 && c != 10)
          c = $fgetc(fd);  // Comment runs to the end of the line.
      else if (kind == "P")
        apply_reset();
      else if (kind == "W" || kind == "E")
      begin
        code = (kind == "W") ? $fscanf(fd, "%h %h", f1, f2) : $fscanf(fd, "%h %h %h", f1, f2, f3);
        if (code != ((kind == "W") ? 2 : 3))
        begin
          errors++;
          done = 1'b1;
          $display("A %s record in the stim file has missing fields", kind);
        end
        else if (kind == "W")
          load_word(f1, f2);
        else
        begin
          programs++;
          run_program(f1, f2, f3, timed_out);
          done = timed_out;
        end
      end
    end
    if (fd != 0)
      $fclose(fd);
    if (programs == 0)
    begin
      errors++;
      $display("No program was run from the stim file");
    end
    $display("Summary: %0d programs, %0d checks, %0d errors", programs, checks, errors);
    if (errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

// File: verilog.f
hw/fetch_pkg.sv
hw/pc_gen.sv
hw/icache_ifu.sv
hw/inst_mem.sv
hw/inst_retire.sv
hw/fetch_top.sv
sim/fetch_tb.sv
